// ==== filelist.f ====
+incdir+sim
rtl/rv_decode_pkg.sv
rtl/decoded_if.sv
rtl/imm_gen.sv
rtl/instr_decoder.sv
rtl/dispatch_reg.sv
rtl/decode_stage.sv
sim/tb_decode_stage.sv

// ==== rtl/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

// Decode stage top, decoder plus one register
module decode_stage (
    input  logic        clk,
    input  logic        reset,
    input  logic        in_valid,
    input  logic [31:0] in_instr,
    input  logic [63:0] in_pc,
    input  logic        stall,
    output logic        out_valid,
    output logic        out_illegal,
    output logic [63:0] out_pc,
    output logic [2:0]  out_op_type,
    output logic [2:0]  out_op,
    output logic        out_option,
    output logic        out_truncate,
    output logic [1:0]  out_br_type,
    output logic        out_mem_sign,
    output logic [1:0]  out_mem_width,
    output logic [1:0]  out_operand1,
    output logic [1:0]  out_operand2,
    output logic [63:0] out_imm,
    output logic        out_wb_en,
    output logic        out_fencei,
    output logic [4:0]  out_rs1,
    output logic [4:0]  out_rs2,
    output logic [4:0]  out_rd
);

    // Decoded fields, valid in the same cycle as in_instr
    decoded_if dec_bus ();

    instr_decoder u_decoder (
        .instr (in_instr),
        .dec   (dec_bus)
    );

    // Capture and hold under stall
    dispatch_reg u_dispatch (
        .clk           (clk),
        .reset         (reset),
        .stall         (stall),
        .in_valid      (in_valid),
        .in_pc         (in_pc),
        .dec           (dec_bus),
        .out_valid     (out_valid),
        .out_illegal   (out_illegal),
        .out_pc        (out_pc),
        .out_op_type   (out_op_type),
        .out_op        (out_op),
        .out_option    (out_option),
        .out_truncate  (out_truncate),
        .out_br_type   (out_br_type),
        .out_mem_sign  (out_mem_sign),
        .out_mem_width (out_mem_width),
        .out_operand1  (out_operand1),
        .out_operand2  (out_operand2),
        .out_imm       (out_imm),
        .out_wb_en     (out_wb_en),
        .out_fencei    (out_fencei),
        .out_rs1       (out_rs1),
        .out_rs2       (out_rs2),
        .out_rd        (out_rd)
    );

endmodule

`default_nettype wire

// ==== rtl/decoded_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// One decoded instruction, decoder to stage register
interface decoded_if;

    // Integer pipe controls
    logic [2:0]  op_type;
    logic [2:0]  op;
    logic        option;
    logic        truncate;
    logic [1:0]  br_type;
    // Load/store pipe controls
    logic        mem_sign;
    logic [1:0]  mem_width;
    // Shared controls
    logic [1:0]  operand1;
    logic [1:0]  operand2;
    logic [63:0] imm;
    logic        wb_en;
    logic        legal;
    logic        fencei;
    // Raw register fields
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;

    modport source (
        output op_type, op, option, truncate, br_type,
        output mem_sign, mem_width,
        output operand1, operand2, imm, wb_en, legal, fencei,
        output rs1, rs2, rd
    );

    modport sink (
        input op_type, op, option, truncate, br_type,
        input mem_sign, mem_width,
        input operand1, operand2, imm, wb_en, legal, fencei,
        input rs1, rs2, rd
    );

endinterface

`default_nettype wire

// ==== rtl/dispatch_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

// Decode/dispatch stage register
module dispatch_reg (
    input  logic        clk,
    input  logic        reset,
    input  logic        stall,
    input  logic        in_valid,
    input  logic [63:0] in_pc,
    decoded_if.sink     dec,
    output logic        out_valid,
    output logic        out_illegal,
    output logic [63:0] out_pc,
    output logic [2:0]  out_op_type,
    output logic [2:0]  out_op,
    output logic        out_option,
    output logic        out_truncate,
    output logic [1:0]  out_br_type,
    output logic        out_mem_sign,
    output logic [1:0]  out_mem_width,
    output logic [1:0]  out_operand1,
    output logic [1:0]  out_operand2,
    output logic [63:0] out_imm,
    output logic        out_wb_en,
    output logic        out_fencei,
    output logic [4:0]  out_rs1,
    output logic [4:0]  out_rs2,
    output logic [4:0]  out_rd
);

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid     <= 1'b0;
            out_illegal   <= 1'b0;
            out_wb_en     <= 1'b0;
            out_pc        <= 64'd0;
            out_op_type   <= 3'd0;
            out_op        <= 3'd0;
            out_option    <= 1'b0;
            out_truncate  <= 1'b0;
            out_br_type   <= 2'd0;
            out_mem_sign  <= 1'b0;
            out_mem_width <= 2'd0;
            out_operand1  <= 2'd0;
            out_operand2  <= 2'd0;
            out_imm       <= 64'd0;
            out_fencei    <= 1'b0;
            out_rs1       <= 5'd0;
            out_rs2       <= 5'd0;
            out_rd        <= 5'd0;
        end else if (!stall) begin
            out_valid     <= in_valid;
            // Exception path needs the flag only for a real instruction
            out_illegal   <= in_valid && !dec.legal;
            // Never write back from an illegal encoding
            out_wb_en     <= dec.wb_en && dec.legal;
            // PC travels with its fields
            out_pc        <= in_pc;
            out_op_type   <= dec.op_type;
            out_op        <= dec.op;
            out_option    <= dec.option;
            out_truncate  <= dec.truncate;
            out_br_type   <= dec.br_type;
            out_mem_sign  <= dec.mem_sign;
            out_mem_width <= dec.mem_width;
            out_operand1  <= dec.operand1;
            out_operand2  <= dec.operand2;
            out_imm       <= dec.imm;
            out_fencei    <= dec.fencei;
            out_rs1       <= dec.rs1;
            out_rs2       <= dec.rs2;
            out_rd        <= dec.rd;
        end
        // Stall high, everything holds
    end

endmodule

`default_nettype wire

// ==== rtl/imm_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

// Sign-extended immediate for the format chosen by the decoder
module imm_gen (
    input  rv_decode_pkg::instr_t instr,
    input  rv_decode_pkg::fmt_t   fmt,
    output logic [63:0]           imm
);

    import rv_decode_pkg::*;

    always_comb begin
        case (fmt)
            fmt_i: begin
                // imm[11:0] straight from the top
                imm = {{52{instr.i.imm12[11]}}, instr.i.imm12};
            end
            fmt_s: begin
                // Split across funct7 and rd slots
                imm = {{52{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
            end
            fmt_b: begin
                // Halfword offset, bit 0 always zero
                imm = {{51{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                       instr.b.imm10_5, instr.b.imm4_1, 1'b0};
            end
            fmt_u: begin
                // Upper 20 bits, low 12 cleared, RV64 sign-extends the result
                imm = {{32{instr.u.imm20[19]}}, instr.u.imm20, 12'd0};
            end
            fmt_j: begin
                // Jump offset, scrambled order
                imm = {{43{instr.j.imm20}}, instr.j.imm20, instr.j.imm19_12,
                       instr.j.imm11, instr.j.imm10_1, 1'b0};
            end
            default: begin
                // No immediate
                imm = 64'd0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/instr_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

// Purely combinational RV64I decoder
module instr_decoder (
    input  logic [31:0]     instr,
    decoded_if.source       dec
);

    import rv_decode_pkg::*;

    instr_t      word;
    fmt_t        fmt;
    logic [63:0] imm_val;
    logic [6:0]  funct7;
    logic [2:0]  funct3;

    assign word   = instr;
    assign funct7 = word.r.funct7;
    assign funct3 = word.r.funct3;

    // Register fields are always passed raw
    assign dec.rs1 = word.r.rs1;
    assign dec.rs2 = word.r.rs2;
    assign dec.rd  = word.r.rd;

    // Immediate built off the format picked below
    imm_gen u_imm_gen (
        .instr (word),
        .fmt   (fmt),
        .imm   (imm_val)
    );

    assign dec.imm = imm_val;

    always_comb begin
        // Unused fields stay zero, illegal until proven otherwise
        dec.op_type   = ot_int;
        dec.op        = alu_addsub;
        dec.option    = aluopt_add;
        dec.truncate  = 1'b0;
        dec.br_type   = bt_none;
        dec.mem_sign  = 1'b0;
        dec.mem_width = 2'd0;
        dec.operand1  = opr1_rs1;
        dec.operand2  = opr2_rs2;
        dec.wb_en     = 1'b0;
        dec.legal     = 1'b0;
        dec.fencei    = 1'b0;
        fmt           = fmt_none;

        case (word.r.opcode)
            op_lui, op_auipc: begin
                // rd = 0/pc + imm
                dec.operand1 = (word.r.opcode == op_lui) ? opr1_zero : opr1_pc;
                dec.operand2 = opr2_imm;
                fmt          = fmt_u;
                dec.wb_en    = 1'b1;
                dec.legal    = 1'b1;
            end
            op_intimm, op_intimmw: begin
                dec.op       = funct3;
                dec.truncate = (word.r.opcode == op_intimmw);
                dec.operand2 = opr2_imm;
                fmt          = fmt_i;
                dec.wb_en    = 1'b1;
                dec.legal    = 1'b1;
                // srli vs srai
                if (funct3 == 3'b101)
                    dec.option = funct7[5];
                // Shift amount is 6 bits wide, 5 bits for the W forms
                if (word.r.opcode == op_intimm) begin
                    if ((funct3 == 3'b001) && (funct7[6:1] != 6'd0))
                        dec.legal = 1'b0;
                    if ((funct3 == 3'b101) && ((funct7[6] != 1'b0) || (funct7[4:1] != 4'd0)))
                        dec.legal = 1'b0;
                end else begin
                    if ((funct3 == 3'b001) && (funct7 != 7'd0))
                        dec.legal = 1'b0;
                    else if ((funct3 == 3'b101) && ((funct7[6] != 1'b0) || (funct7[4:0] != 5'd0)))
                        dec.legal = 1'b0;
                    else if ((funct3 != 3'b000) && (funct3 != 3'b001) && (funct3 != 3'b101))
                        dec.legal = 1'b0;
                end
            end
            op_intreg: begin
                dec.op     = funct3;
                dec.option = funct7[5];
                dec.wb_en  = 1'b1;
                dec.legal  = 1'b1;
                // add/sub and srl/sra take funct7[5], everything else needs zero
                if ((funct3 == 3'b000) || (funct3 == 3'b101)) begin
                    if ((funct7[6] != 1'b0) || (funct7[4:0] != 5'd0))
                        dec.legal = 1'b0;
                end else if (funct7 != 7'd0) begin
                    dec.legal = 1'b0;
                end
            end
            op_intregw: begin
                dec.op       = funct3;
                dec.option   = funct7[5];
                dec.truncate = 1'b1;
                dec.wb_en    = 1'b1;
                dec.legal    = 1'b1;
                if ((funct3 == 3'b000) || (funct3 == 3'b101)) begin
                    if ((funct7[6] != 1'b0) || (funct7[4:0] != 5'd0))
                        dec.legal = 1'b0;
                end else if (funct3 == 3'b001) begin
                    if (funct7 != 7'd0)
                        dec.legal = 1'b0;
                end else begin
                    // mulw/divw/remw family, no M extension here
                    dec.legal = 1'b0;
                end
            end
            op_jal: begin
                // Target = pc + imm, rd gets the link
                dec.op_type  = ot_branch;
                dec.operand1 = opr1_pc;
                dec.operand2 = opr2_imm;
                dec.br_type  = bt_jal;
                fmt          = fmt_j;
                dec.wb_en    = 1'b1;
                dec.legal    = 1'b1;
            end
            op_jalr: begin
                dec.op_type  = ot_branch;
                dec.operand2 = opr2_imm;
                dec.br_type  = bt_jalr;
                fmt          = fmt_i;
                dec.wb_en    = 1'b1;
                dec.legal    = 1'b1;
            end
            op_branch: begin
                // Compare rs1 against rs2, funct3 is the condition
                dec.op_type = ot_branch;
                dec.op      = funct3;
                dec.br_type = bt_bcond;
                fmt         = fmt_b;
                dec.legal   = (funct3 != 3'b010) && (funct3 != 3'b011);
            end
            op_load: begin
                dec.op_type   = ot_load;
                dec.mem_sign  = funct3[2];
                dec.mem_width = funct3[1:0];
                dec.operand2  = opr2_imm;
                fmt           = fmt_i;
                dec.wb_en     = 1'b1;
                // No unsigned doubleword
                dec.legal     = (funct3 != 3'b111);
            end
            op_store: begin
                dec.op_type   = ot_store;
                dec.mem_sign  = funct3[2];
                dec.mem_width = funct3[1:0];
                fmt           = fmt_s;
                dec.legal     = (funct3[2] == 1'b0);
            end
            op_fence: begin
                dec.op_type = ot_fence;
                // Plain fence: fm, rs1, funct3, rd all zero
                if ((instr[31:28] == 4'd0) && (instr[19:7] == 13'd0)) begin
                    dec.legal = 1'b1;
                end else if (instr[31:7] == 25'b0000000000000000000100000) begin
                    dec.fencei = 1'b1;
                    dec.legal  = 1'b1;
                end
            end
            op_envcsr: begin
                // No CSR unit yet, treat as nop and flag ecall only
                dec.op_type  = ot_csr;
                dec.operand1 = opr1_zero;
                dec.operand2 = opr2_imm;
                dec.option   = (instr == 32'h0000_0073);
                dec.legal    = 1'b1;
            end
            default: begin
                // Unknown opcode, defaults already say illegal
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/rv_decode_pkg.sv ====
`default_nettype none

package rv_decode_pkg;

    // Major opcodes, instr[6:0]
    localparam logic [6:0] op_lui     = 7'b0110111;
    localparam logic [6:0] op_auipc   = 7'b0010111;
    localparam logic [6:0] op_intimm  = 7'b0010011;
    localparam logic [6:0] op_intreg  = 7'b0110011;
    localparam logic [6:0] op_intimmw = 7'b0011011;
    localparam logic [6:0] op_intregw = 7'b0111011;
    localparam logic [6:0] op_jal     = 7'b1101111;
    localparam logic [6:0] op_jalr    = 7'b1100111;
    localparam logic [6:0] op_branch  = 7'b1100011;
    localparam logic [6:0] op_load    = 7'b0000011;
    localparam logic [6:0] op_store   = 7'b0100011;
    localparam logic [6:0] op_fence   = 7'b0001111;
    localparam logic [6:0] op_envcsr  = 7'b1110011;

    // Op type, picks the downstream pipe
    localparam logic [2:0] ot_int    = 3'd0;
    localparam logic [2:0] ot_branch = 3'd1;
    localparam logic [2:0] ot_load   = 3'd2;
    localparam logic [2:0] ot_store  = 3'd3;
    localparam logic [2:0] ot_fence  = 3'd4;
    localparam logic [2:0] ot_csr    = 3'd5;

    // ALU op, all others are funct3 as is
    localparam logic [2:0] alu_addsub = 3'd0;

    // ALU option bit
    localparam logic aluopt_add = 1'b0;
    localparam logic aluopt_sub = 1'b1;

    // Operand 1 source
    localparam logic [1:0] opr1_rs1  = 2'd0;
    localparam logic [1:0] opr1_pc   = 2'd1;
    localparam logic [1:0] opr1_zero = 2'd2;

    // Operand 2 source
    localparam logic [1:0] opr2_rs2 = 2'd0;
    localparam logic [1:0] opr2_imm = 2'd1;

    // Branch kind
    localparam logic [1:0] bt_none  = 2'd0;
    localparam logic [1:0] bt_jal   = 2'd1;
    localparam logic [1:0] bt_jalr  = 2'd2;
    localparam logic [1:0] bt_bcond = 2'd3;

    // Immediate format handed to the immediate generator
    typedef enum logic [2:0] {
        fmt_i,
        fmt_s,
        fmt_b,
        fmt_u,
        fmt_j,
        fmt_none
    } fmt_t;

    // One 32-bit word, six encodings
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] imm_hi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s;
        struct packed {
            logic       imm12;
            logic [5:0] imm10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4_1;
            logic       imm11;
            logic [6:0] opcode;
        } b;
        struct packed {
            logic [19:0] imm20;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u;
        struct packed {
            logic       imm20;
            logic [9:0] imm10_1;
            logic       imm11;
            logic [7:0] imm19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j;
    } instr_t;

endpackage

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build the decode stage testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 --top-module tb_decode_stage -f filelist.f \
    && ./obj_dir/Vtb_decode_stage | grep "TESTS PASSED" \
    || exit 1

exit 0

// ==== sim/decode_ref_model.svh ====
`ifndef DECODE_REF_MODEL_SVH
`define DECODE_REF_MODEL_SVH

// Expected decoder fields for one instruction word
typedef struct {
    logic [2:0]  op_type;
    logic [2:0]  op;
    logic        option;
    logic        truncate;
    logic [1:0]  br_type;
    logic        mem_sign;
    logic [1:0]  mem_width;
    logic [1:0]  operand1;
    logic [1:0]  operand2;
    logic [63:0] imm;
    logic        wb_en;
    logic        legal;
    logic        fencei;
} exp_fields_t;

// Decode straight from the RV64I bit layouts
function automatic exp_fields_t ref_decode(input logic [31:0] w);
    exp_fields_t e;
    logic [6:0]  f7;
    logic [2:0]  f3;
    logic [63:0] imm_i;
    logic [63:0] imm_s;
    logic [63:0] imm_b;
    logic [63:0] imm_u;
    logic [63:0] imm_j;
    f7    = w[31:25];
    f3    = w[14:12];
    imm_i = {{52{w[31]}}, w[31:20]};
    imm_s = {{52{w[31]}}, w[31:25], w[11:7]};
    imm_b = {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    imm_u = {{32{w[31]}}, w[31:12], 12'h000};
    imm_j = {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    // Unused fields zero, unknown opcode illegal
    e = '{default: '0};
    case (w[6:0])
        op_lui, op_auipc: begin
            e.operand1 = (w[6:0] == op_lui) ? opr1_zero : opr1_pc;
            e.operand2 = opr2_imm;
            e.imm      = imm_u;
            e.wb_en    = 1'b1;
            e.legal    = 1'b1;
        end
        op_intimm, op_intimmw: begin
            e.op       = f3;
            e.truncate = (w[6:0] == op_intimmw);
            e.operand2 = opr2_imm;
            e.imm      = imm_i;
            e.wb_en    = 1'b1;
            e.option   = (f3 == 3'd5) && f7[5];
            // 64-bit shifts keep funct7 bit 0 as shamt[5]
            if (!e.truncate)
                e.legal = (f3 == 3'd1) ? (f7[6:1] == 6'd0) :
                          (f3 == 3'd5) ? ((f7[6:1] == 6'd0) || (f7[6:1] == 6'b010000)) : 1'b1;
            else
                e.legal = (f3 == 3'd0) || ((f3 == 3'd1) && (f7 == 7'd0)) ||
                          ((f3 == 3'd5) && ((f7 == 7'd0) || (f7 == 7'h20)));
        end
        op_intreg, op_intregw: begin
            e.op       = f3;
            e.option   = f7[5];
            e.truncate = (w[6:0] == op_intregw);
            e.wb_en    = 1'b1;
            if ((f3 == 3'd0) || (f3 == 3'd5))
                e.legal = (f7 == 7'd0) || (f7 == 7'h20);
            else
                e.legal = (f7 == 7'd0);
            // Only addw/subw, sllw, srlw/sraw exist
            if (e.truncate && !(f3 inside {3'd0, 3'd1, 3'd5}))
                e.legal = 1'b0;
        end
        op_jal: begin
            e.op_type  = ot_branch;
            e.operand1 = opr1_pc;
            e.operand2 = opr2_imm;
            e.br_type  = bt_jal;
            e.imm      = imm_j;
            e.wb_en    = 1'b1;
            e.legal    = 1'b1;
        end
        op_jalr: begin
            e.op_type  = ot_branch;
            e.operand2 = opr2_imm;
            e.br_type  = bt_jalr;
            e.imm      = imm_i;
            e.wb_en    = 1'b1;
            e.legal    = 1'b1;
        end
        op_branch: begin
            e.op_type = ot_branch;
            e.op      = f3;
            e.br_type = bt_bcond;
            e.imm     = imm_b;
            e.legal   = !(f3 inside {3'd2, 3'd3});
        end
        op_load: begin
            e.op_type   = ot_load;
            e.mem_sign  = f3[2];
            e.mem_width = f3[1:0];
            e.operand2  = opr2_imm;
            e.imm       = imm_i;
            e.wb_en     = 1'b1;
            e.legal     = (f3 != 3'd7);
        end
        op_store: begin
            e.op_type   = ot_store;
            e.mem_sign  = f3[2];
            e.mem_width = f3[1:0];
            e.imm       = imm_s;
            e.legal     = !f3[2];
        end
        op_fence: begin
            e.op_type = ot_fence;
            e.fencei  = (w == 32'h0000_100f);
            e.legal   = e.fencei || ((w[31:28] == 4'd0) && (w[19:7] == 13'd0));
        end
        op_envcsr: begin
            // SYSTEM is a no-op, ECALL only sets option
            e.op_type  = ot_csr;
            e.operand1 = opr1_zero;
            e.operand2 = opr2_imm;
            e.option   = (w == 32'h0000_0073);
            e.legal    = 1'b1;
        end
        default: begin
        end
    endcase
    return e;
endfunction

`endif

// ==== sim/tb_decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_decode_stage;

    import rv_decode_pkg::*;

    `include "decode_ref_model.svh"

    localparam int n_int     = 2000;
    localparam int n_mem     = 1000;
    localparam int n_illegal = 1000;
    localparam int n_stall   = 2000;
    // Stall phase runs about 1.4x its count plus a margin for reset and flush
    localparam int n_cycles  = n_int + n_mem + n_illegal + 2 * n_stall + 20;

    logic        clk = 1'b0;
    logic        reset;
    logic        in_valid;
    logic [31:0] in_instr;
    logic [63:0] in_pc;
    logic        stall;
    logic        out_valid, out_illegal, out_option, out_truncate;
    logic        out_mem_sign, out_wb_en, out_fencei;
    logic [63:0] out_pc, out_imm;
    logic [2:0]  out_op_type, out_op;
    logic [1:0]  out_br_type, out_mem_width, out_operand1, out_operand2;
    logic [4:0]  out_rs1, out_rs2, out_rd;

    // One-deep expectation for the stage register
    exp_fields_t exp_f;
    logic        exp_valid;
    logic        exp_illegal;
    logic [63:0] exp_pc;
    logic [31:0] exp_instr;
    string       test_name;
    int          issued;
    int          seen;
    logic [63:0] last_pc;

    decode_stage DUT (.*);

    always #50 clk = ~clk;

    task automatic check_value(input string field, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("mismatch %s %s: expected 0x%0h, actual 0x%0h",
                     test_name, field, expected, actual);
            $display("TESTS FAILED");
            $fatal(1);
        end
    endtask

    task automatic compare_outputs();
        check_value("out_valid", 64'(exp_valid), 64'(out_valid));
        check_value("out_illegal", 64'(exp_illegal), 64'(out_illegal));
        check_value("out_pc", exp_pc, out_pc);
        check_value("out_op_type", 64'(exp_f.op_type), 64'(out_op_type));
        check_value("out_op", 64'(exp_f.op), 64'(out_op));
        check_value("out_option", 64'(exp_f.option), 64'(out_option));
        check_value("out_truncate", 64'(exp_f.truncate), 64'(out_truncate));
        check_value("out_br_type", 64'(exp_f.br_type), 64'(out_br_type));
        check_value("out_mem_sign", 64'(exp_f.mem_sign), 64'(out_mem_sign));
        check_value("out_mem_width", 64'(exp_f.mem_width), 64'(out_mem_width));
        check_value("out_operand1", 64'(exp_f.operand1), 64'(out_operand1));
        check_value("out_operand2", 64'(exp_f.operand2), 64'(out_operand2));
        check_value("out_imm", exp_f.imm, out_imm);
        // Illegal encodings never write back
        check_value("out_wb_en", 64'(exp_f.wb_en && exp_f.legal), 64'(out_wb_en));
        check_value("out_fencei", 64'(exp_f.fencei), 64'(out_fencei));
        check_value("out_rs1", 64'(exp_instr[19:15]), 64'(out_rs1));
        check_value("out_rs2", 64'(exp_instr[24:20]), 64'(out_rs2));
        check_value("out_rd", 64'(exp_instr[11:7]), 64'(out_rd));
    endtask

    // Kind 0 is integer/branch, 1 memory/fence, 2 illegal-leaning and 3 any of them
    function automatic logic [31:0] gen_instr(input int kind);
        logic [31:0] w;
        logic [6:0]  opc;
        int          k;
        int          pick;
        w = $urandom;
        k = (kind == 3) ? int'($urandom % 3) : kind;
        // Lean funct7 toward 0, 0x20 and shamt[5]
        pick = $urandom % 8;
        if (pick < 3)
            w[31:25] = 7'h00;
        else if (pick < 5)
            w[31:25] = 7'h20;
        else if (pick == 5)
            w[31:25] = 7'h01;
        pick = $urandom % 9;
        opc  = op_branch;
        if (k == 0) begin
            case (pick)
                0: opc = op_lui;
                1: opc = op_auipc;
                2: opc = op_intimm;
                3: opc = op_intreg;
                4: opc = op_intimmw;
                5: opc = op_intregw;
                6: opc = op_jal;
                7: opc = op_jalr;
                default: opc = op_branch;
            endcase
        end else if (k == 1) begin
            opc = (pick < 3) ? op_load : (pick < 6) ? op_store : op_fence;
            if ((opc == op_fence) && (pick == 6))
                w[31:7] = 25'h20;
            else if ((opc == op_fence) && (pick == 7)) begin
                w[31:28] = 4'd0;
                w[19:7]  = 13'd0;
            end
        end else begin
            case (pick)
                0: begin
                    // Shifts with any funct7
                    opc      = op_intimm;
                    w[31:25] = 7'($urandom);
                    w[13:12] = 2'b01;
                end
                1: opc = op_intregw;
                2: begin
                    opc      = op_branch;
                    w[14:13] = 2'b01;
                end
                3: begin
                    opc      = op_load;
                    w[14:12] = 3'b111;
                end
                4: begin
                    opc   = op_store;
                    w[14] = 1'b1;
                end
                5: begin
                    opc = op_envcsr;
                    if ($urandom % 2 == 0)
                        w = 32'h0000_0073;
                end
                6: opc = op_fence;
                default: begin
                    opc = 7'($urandom);
                    while (opc inside {op_lui, op_auipc, op_intimm, op_intreg, op_intimmw,
                                       op_intregw, op_jal, op_jalr, op_branch, op_load,
                                       op_store, op_fence, op_envcsr})
                        opc = 7'($urandom);
                end
            endcase
        end
        w[6:0] = opc;
        return w;
    endfunction

    // Check what the last edge captured, then drive the next input
    task automatic step(input logic [31:0] instr, input logic [63:0] pc,
                        input logic valid, input logic stall_lvl);
        @(posedge clk);
        #1;
        if (!stall) begin
            exp_instr   = in_instr;
            exp_pc      = in_pc;
            exp_valid   = in_valid;
            exp_f       = ref_decode(in_instr);
            exp_illegal = in_valid && !exp_f.legal;
        end
        compare_outputs();
        // PCs are unique, so a new PC means a new instruction
        if (out_valid && (out_pc != last_pc)) begin
            seen++;
            last_pc = out_pc;
        end
        in_instr = instr;
        in_pc    = pc;
        in_valid = valid;
        stall    = stall_lvl;
    endtask

    task automatic run_phase(input string name, input int kind, input int count,
                             input int stall_pct);
        int          n;
        logic        v;
        test_name = name;
        n = 0;
        while (n < count) begin
            if (stall) begin
                // Held instruction is re-presented until accepted
                step(in_instr, in_pc, in_valid, ($urandom % 100) < stall_pct);
            end else begin
                v = ($urandom % 10) != 0;
                if (v)
                    issued++;
                step(gen_instr(kind), in_pc + 64'd4, v, ($urandom % 100) < stall_pct);
                n++;
            end
        end
    endtask

    initial begin
        #(n_cycles * 100);
        $display("Simulation timed out after %0d cycles", n_cycles);
        $display("TESTS FAILED");
        $fatal(1);
    end

    initial begin
        void'($urandom(32'hee3));
        reset    = 1'b1;
        // Valid jal x1 at a nonzero PC sits at the input during reset
        in_valid = 1'b1;
        in_instr = 32'h0040_00ef;
        in_pc    = 64'h0000_0000_8000_0000;
        stall    = 1'b0;
        issued   = 0;
        seen     = 0;
        last_pc  = 64'd0;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        // Reset values are all zero
        test_name   = "reset";
        exp_f       = '{default: '0};
        exp_valid   = 1'b0;
        exp_illegal = 1'b0;
        exp_pc      = 64'd0;
        exp_instr   = 32'd0;
        compare_outputs();
        // Idle input ahead of the first random instruction
        in_valid = 1'b0;
        in_instr = 32'd0;
        in_pc    = 64'd0;
        run_phase("int_branch", 0, n_int, 0);
        run_phase("mem_fence", 1, n_mem, 0);
        run_phase("illegal", 2, n_illegal, 0);
        run_phase("stall", 3, n_stall, 30);
        // Drain the last instruction
        while (stall)
            step(in_instr, in_pc, in_valid, 1'b0);
        step(32'd0, in_pc + 64'd4, 1'b0, 1'b0);
        step(32'd0, in_pc + 64'd4, 1'b0, 1'b0);
        test_name = "drain";
        check_value("instruction count", 64'(issued), 64'(seen));
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire
